// File: hdl/bg_fetch.sv
`timescale 1ns/1ps

module bg_fetch
(
  input  logic                  I_clock,
  input  logic                  I_reset,
  input  video_pkg::dot_pos_t   dot,
  input  host_pkg::host_event_t host_event,
  input  host_pkg::control_t    control,
  input  host_pkg::mask_t       mask,
  input  logic [7:0]            vid_rdata,
  output logic [13:0]           vid_addr,
  output video_pkg::vram_addr_t cursor,
  output video_pkg::pixel_t     bg_pixel
);
  import video_pkg::*;

  vram_addr_t    t_addr;
  logic [2:0]    fine_x;
  logic [7:0]    tile_index;
  logic [1:0]    tile_attr;
  logic [7:0]    tile_lo;
  pixel_t [15:0] shifter;
  fetch_phase_e  phase;
  logic [2:0]    group_dot;
  logic [1:0]    attr_sel;
  logic [14:0]   step;
  logic          render_on;
  logic          fetch_active;
  logic          group_end;

  assign group_dot = dot.x[2:0] - 3'd1;
  assign phase     = fetch_phase_e'(group_dot[2:1]);
  assign group_end = (dot.x[2:0] == 3'd0);
  assign attr_sel  = {cursor.coarse_y[1], cursor.coarse_x[1]};
  assign step      = host_event.inc32 ? 15'd32 : 15'd1;

  assign render_on = mask.show_background
                   & ((dot.y < visible_lines) | (dot.y == prerender_line));

  // Visible fetches plus the two-tile prefetch for the next line
  assign fetch_active = render_on
                      & (((dot.x >= 16'd1) & (dot.x <= visible_width))
                      | ((dot.x >= 16'd321) & (dot.x <= 16'd336)));

  assign bg_pixel = shifter[{1'b0, fine_x}];

  //////////////////////////////////////////////////
  // Fetch address

  always_comb
  begin
    vid_addr = cursor[13:0];
    if (fetch_active)
    begin
      case (phase)
        nametable:
          vid_addr = {2'b10, cursor[11:0]};
        attribute:
          vid_addr = {2'b10, cursor.nametable_y, cursor.nametable_x, 4'hF,
                      cursor.coarse_y[4:2], cursor.coarse_x[4:2]};
        pattern_lo:
          vid_addr = {1'b0, control.background_base, tile_index, 1'b0, cursor.fine_y};
        pattern_hi:
          vid_addr = {1'b0, control.background_base, tile_index, 1'b1, cursor.fine_y};
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Capture, shift and scroll

  always_ff @(posedge I_clock, negedge I_reset)
  begin
    if (!I_reset)
    begin
      cursor     <= '0;
      t_addr     <= '0;
      fine_x     <= 3'd0;
      tile_index <= 8'd0;
      tile_attr  <= 2'd0;
      tile_lo    <= 8'd0;
      shifter    <= '0;
    end
    else
    begin
      if (dot.tick & fetch_active)
      begin
        shifter <= {pixel_t'(4'd0), shifter[15:1]};
        // Second dot of each fetch pair takes the byte
        if (!dot.x[0])
        begin
          case (phase)
            nametable:  tile_index <= vid_rdata;
            attribute:  tile_attr  <= vid_rdata[{attr_sel, 1'b0} +: 2];
            pattern_lo: tile_lo    <= vid_rdata;
            pattern_hi:
            begin
              // Leftmost pixel is bit 7
              for (int i = 0; i < 8; i++)
                shifter[15 - i] <= {tile_attr, vid_rdata[i], tile_lo[i]};
            end
            default: ;
          endcase
        end
      end

      if (dot.tick & render_on)
      begin
        if (fetch_active & group_end)
        begin
          cursor.coarse_x <= cursor.coarse_x + 5'd1;
          if (cursor.coarse_x == 5'd31)
            cursor.nametable_x <= ~cursor.nametable_x;
        end
        if (dot.x == visible_width)
        begin
          cursor.fine_y <= cursor.fine_y + 3'd1;
          if (cursor.fine_y == 3'd7)
          begin
            // Row 29 is the last tile row of a nametable
            if (cursor.coarse_y == 5'd29)
            begin
              cursor.coarse_y    <= 5'd0;
              cursor.nametable_y <= ~cursor.nametable_y;
            end
            else
              cursor.coarse_y <= cursor.coarse_y + 5'd1;
          end
        end
        if (dot.x == visible_width + 16'd1)
        begin
          cursor.nametable_x <= t_addr.nametable_x;
          cursor.coarse_x    <= t_addr.coarse_x;
        end
        if ((dot.y == prerender_line) && (dot.x >= 16'd280) && (dot.x <= 16'd304))
        begin
          cursor.nametable_y <= t_addr.nametable_y;
          cursor.coarse_y    <= t_addr.coarse_y;
          cursor.fine_y      <= t_addr.fine_y;
        end
      end

      // Host side
      if (host_event.nametable_wr)
        {t_addr.nametable_y, t_addr.nametable_x} <= host_event.data[1:0];
      if (host_event.scroll_wr)
      begin
        if (host_event.latch)
        begin
          t_addr.coarse_y <= host_event.data[7:3];
          t_addr.fine_y   <= host_event.data[2:0];
        end
        else
        begin
          t_addr.coarse_x <= host_event.data[7:3];
          fine_x          <= host_event.data[2:0];
        end
      end
      if (host_event.addr_wr)
      begin
        if (host_event.latch)
        begin
          t_addr[7:0] <= host_event.data;
          cursor      <= vram_addr_t'({t_addr[14:8], host_event.data});
        end
        else
          t_addr[14:8] <= {1'b0, host_event.data[5:0]};
      end
      if (host_event.access)
        cursor <= vram_addr_t'(cursor + step);
    end
  end

endmodule

// File: hdl/dot_timer.sv
`timescale 1ns/1ps

module dot_timer
(
  input  logic                I_clock,
  input  logic                I_reset,
  output video_pkg::dot_pos_t dot,
  output logic                hsync,
  output logic                vsync,
  output logic                blank
);
  import video_pkg::*;

  logic [1:0] clk_div;
  logic       tick;
  dot_count_t dot_x;
  dot_count_t dot_y;

  // One dot every fourth clock
  assign tick = (clk_div == 2'd3);

  always_ff @(posedge I_clock, negedge I_reset)
  begin
    if (!I_reset)
    begin
      clk_div <= 2'd0;
      dot_x   <= '0;
      dot_y   <= '0;
    end
    else
    begin
      clk_div <= clk_div + 2'd1;
      if (tick)
      begin
        if (dot_x == dots_per_line - 16'd1)
        begin
          dot_x <= '0;
          if (dot_y == lines_per_frame - 16'd1)
            dot_y <= '0;
          else
            dot_y <= dot_y + 16'd1;
        end
        else
          dot_x <= dot_x + 16'd1;
      end
    end
  end

  assign dot = '{tick: tick, x: dot_x, y: dot_y};

  // Syncs low inside their windows
  assign hsync = !((dot_x >= hsync_start) && (dot_x <= hsync_end));
  assign vsync = !((dot_y >= vsync_start) && (dot_y <= vsync_end));

  // High over the visible picture, dots 1 to 256
  assign blank = (dot_x >= 16'd1) && (dot_x <= visible_width) && (dot_y < visible_lines);

endmodule

// File: hdl/host_pkg.sv
package host_pkg;

  // Host register map, one byte each
  typedef enum logic [2:0]
  {
    reg_control, reg_mask, reg_status, reg_oam_addr,
    reg_oam_data, reg_scroll, reg_vram_addr, reg_vram_data
  } host_reg_e;

  typedef struct packed
  {
    logic       enable_nmi;
    logic       master_slave;
    logic       sprite_size;
    logic       background_base;
    logic       sprite_base;
    logic       increment;
    logic [1:0] nametable;
  } control_t;

  typedef struct packed
  {
    logic emphasize_blue;
    logic emphasize_green;
    logic emphasize_red;
    logic show_sprites;
    logic show_background;
    logic show_left_sprites;
    logic show_left_background;
    logic grayscale;
  } mask_t;

  // Register side effects handed to the fetch unit
  typedef struct packed
  {
    logic       scroll_wr;
    logic       addr_wr;
    logic       latch;
    logic [7:0] data;
    logic       nametable_wr;
    logic       access;
    logic       inc32;
  } host_event_t;

  // Cursor bits 13..8 that select palette space
  localparam logic [5:0] palette_base = 6'h3F;

endpackage

// File: hdl/host_regs.sv
`timescale 1ns/1ps

module host_regs
(
  input  logic                  I_clock,
  input  logic                  I_reset,
  input  host_pkg::host_reg_e   host_addr,
  input  logic [7:0]            host_data,
  input  logic                  host_wren,
  input  logic                  host_rden,
  output logic [7:0]            host_rdata,
  output logic                  nmi,
  input  video_pkg::dot_pos_t   dot,
  input  video_pkg::vram_addr_t cursor,
  input  logic [7:0]            vid_rdata,
  input  logic [5:0]            palette_rdata,
  output host_pkg::host_event_t host_event,
  output host_pkg::control_t    control,
  output host_pkg::mask_t       mask,
  output logic                  palette_wren,
  output logic                  vid_wren
);
  import video_pkg::*;
  import host_pkg::*;

  logic       sel_control;
  logic       sel_mask;
  logic       sel_status;
  logic       sel_scroll;
  logic       sel_vram_addr;
  logic       sel_vram_data;
  logic       palette_access;
  logic       line_start;
  logic       write_latch;
  logic       vblank;
  logic [7:0] read_buffer;
  logic [7:0] bus_value;

  //////////////////////////////////////////////////
  // Decode and routing

  assign sel_control   = (host_addr == reg_control);
  assign sel_mask      = (host_addr == reg_mask);
  assign sel_status    = (host_addr == reg_status);
  assign sel_scroll    = (host_addr == reg_scroll);
  assign sel_vram_addr = (host_addr == reg_vram_addr);
  assign sel_vram_data = (host_addr == reg_vram_data);

  assign palette_access = (cursor[13:8] == palette_base);
  assign palette_wren   = host_wren & sel_vram_data & palette_access;
  assign vid_wren       = host_wren & sel_vram_data & ~palette_access;

  always_comb
  begin
    host_event.scroll_wr    = host_wren & sel_scroll;
    host_event.addr_wr      = host_wren & sel_vram_addr;
    host_event.latch        = write_latch;
    host_event.data         = host_data;
    host_event.nametable_wr = host_wren & sel_control;
    host_event.access       = (host_wren | host_rden) & sel_vram_data;
    host_event.inc32        = control.increment;
  end

  //////////////////////////////////////////////////
  // Register state

  always_ff @(posedge I_clock, negedge I_reset)
  begin
    if (!I_reset)
    begin
      control     <= '0;
      mask        <= '0;
      write_latch <= 1'b0;
      read_buffer <= 8'd0;
      bus_value   <= 8'd0;
    end
    else
    begin
      if (host_wren & sel_control)
        control <= control_t'(host_data);
      if (host_wren & sel_mask)
        mask <= mask_t'(host_data);

      // Status read resets the shared first/second write toggle
      if (host_rden & sel_status)
        write_latch <= 1'b0;
      else if (host_wren & (sel_scroll | sel_vram_addr))
        write_latch <= ~write_latch;

      // Refilled after the read, so data lags one access
      if (host_rden & sel_vram_data & ~palette_access)
        read_buffer <= vid_rdata;

      if (host_wren)
        bus_value <= host_data;
      else if (host_rden)
        bus_value <= host_rdata;
    end
  end

  // Vblank flag and NMI
  assign line_start = dot.tick & (dot.x == 16'd0);

  always_ff @(posedge I_clock, negedge I_reset)
  begin
    if (!I_reset)
      vblank <= 1'b0;
    else if (host_rden & sel_status)
      vblank <= 1'b0;
    else if (line_start && (dot.y == vblank_line))
      vblank <= 1'b1;
    else if (line_start && (dot.y == prerender_line))
      vblank <= 1'b0;
  end

  assign nmi = ~(control.enable_nmi & vblank);

  //////////////////////////////////////////////////
  // Read mux, unused bits return the last bus value

  always_comb
  begin
    host_rdata = bus_value;
    case (host_addr)
      reg_status:
        host_rdata[7] = vblank;
      reg_vram_data:
      begin
        if (palette_access)
          host_rdata[5:0] = palette_rdata;
        else
          host_rdata = read_buffer;
      end
      default:
      begin
        // Write-only and OAM registers float to open bus
      end
    endcase
  end

endmodule

// File: hdl/nes_colors.mem
// 64 colour table entries as RRGGBB, eight per line, index 0x00 first
7C7C7C 0000FC 0000BC 4428BC 940084 A80020 A81000 881400
503000 007800 006800 005800 004058 000000 000000 000000
BCBCBC 0078F8 0058F8 6844FC D800CC E40058 F83800 E45C10
AC7C00 00B800 00A800 00A844 008888 000000 000000 000000
F8F8F8 3CBCFC 6888FC 9878F8 F878F8 F85898 F87858 FCA044
F8B800 B8F818 58D854 58F898 00E8D8 787878 000000 000000
FCFCFC A4E4FC B8B8F8 D8B8F8 F8B8F8 F8A4C0 F0D0B0 FCE0A8
F8D878 D8F878 B8F8B8 B8F8D8 00FCFC F8D8F8 000000 000000

// File: hdl/pixel_out.sv
`timescale 1ns/1ps

module pixel_out
(
  input  logic                I_clock,
  input  video_pkg::dot_pos_t dot,
  input  host_pkg::mask_t     mask,
  input  video_pkg::pixel_t   bg_pixel,
  input  logic                palette_wren,
  input  logic [4:0]          palette_addr,
  input  logic [7:0]          host_data,
  output logic [5:0]          palette_rdata,
  output video_pkg::rgb_t     rgb
);
  import video_pkg::*;

  logic [5:0]  palette_ram [0:31];
  logic [23:0] color_table [0:63];
  logic [4:0]  host_index;
  logic [4:0]  color_sel;
  logic [5:0]  color_index;
  logic        left_column;
  logic        show_bg;

  initial
  begin
    $readmemh("hdl/nes_colors.mem", color_table);
  end

  // Entries 10, 14, 18, 1C alias the backdrop slots below
  assign host_index    = {palette_addr[4] & (|palette_addr[1:0]), palette_addr[3:0]};
  assign palette_rdata = palette_ram[host_index];

  assign left_column = (dot.x < 16'd9);
  assign show_bg     = mask.show_background & (mask.show_left_background | ~left_column);

  // Transparent pixels fall back to the backdrop
  always_comb
  begin
    color_sel = 5'd0;
    if (show_bg && (bg_pixel.value != 2'd0))
      color_sel = {1'b0, bg_pixel};
  end

  always_ff @(posedge I_clock)
  begin
    if (palette_wren)
      palette_ram[host_index] <= host_data[5:0];
    color_index <= palette_ram[color_sel];
    rgb         <= rgb_t'(color_table[color_index]);
  end

endmodule

// File: hdl/ppu_top.sv
`timescale 1ns/1ps

module ppu_top
(
  input  logic                I_clock,
  input  logic                I_reset,
  input  host_pkg::host_reg_e host_addr,
  input  logic [7:0]          host_data,
  input  logic                host_wren,
  input  logic                host_rden,
  output logic [7:0]          host_rdata,
  output logic                nmi,
  output logic [13:0]         vid_addr,
  output logic [7:0]          vid_wdata,
  input  logic [7:0]          vid_rdata,
  output logic                vid_wren,
  output logic                vid_rise,
  output logic                blank,
  output logic                hsync,
  output logic                vsync,
  output logic [7:0]          red,
  output logic [7:0]          green,
  output logic [7:0]          blue
);
  import video_pkg::*;
  import host_pkg::*;

  dot_pos_t    dot;
  host_event_t host_event;
  control_t    control;
  mask_t       mask;
  vram_addr_t  cursor;
  pixel_t      bg_pixel;
  logic        palette_wren;
  logic [5:0]  palette_rdata;
  rgb_t        rgb;

  assign vid_rise  = dot.tick;
  assign vid_wdata = host_data;
  assign red       = rgb.red;
  assign green     = rgb.green;
  assign blue      = rgb.blue;

  dot_timer u_dot_timer
  (
    .I_clock (I_clock),
    .I_reset (I_reset),
    .dot     (dot),
    .hsync   (hsync),
    .vsync   (vsync),
    .blank   (blank)
  );

  host_regs u_host_regs
  (
    .I_clock       (I_clock),
    .I_reset       (I_reset),
    .host_addr     (host_addr),
    .host_data     (host_data),
    .host_wren     (host_wren),
    .host_rden     (host_rden),
    .host_rdata    (host_rdata),
    .nmi           (nmi),
    .dot           (dot),
    .cursor        (cursor),
    .vid_rdata     (vid_rdata),
    .palette_rdata (palette_rdata),
    .host_event    (host_event),
    .control       (control),
    .mask          (mask),
    .palette_wren  (palette_wren),
    .vid_wren      (vid_wren)
  );

  bg_fetch u_bg_fetch
  (
    .I_clock    (I_clock),
    .I_reset    (I_reset),
    .dot        (dot),
    .host_event (host_event),
    .control    (control),
    .mask       (mask),
    .vid_rdata  (vid_rdata),
    .vid_addr   (vid_addr),
    .cursor     (cursor),
    .bg_pixel   (bg_pixel)
  );

  pixel_out u_pixel_out
  (
    .I_clock       (I_clock),
    .dot           (dot),
    .mask          (mask),
    .bg_pixel      (bg_pixel),
    .palette_wren  (palette_wren),
    .palette_addr  (cursor[4:0]),
    .host_data     (host_data),
    .palette_rdata (palette_rdata),
    .rgb           (rgb)
  );

endmodule

// File: hdl/video_pkg.sv
package video_pkg;

  // Frame geometry in dots and lines
  localparam logic [15:0] dots_per_line   = 16'd341;
  localparam logic [15:0] lines_per_frame = 16'd262;
  localparam logic [15:0] visible_width   = 16'd256;
  localparam logic [15:0] visible_lines   = 16'd240;
  localparam logic [15:0] vblank_line     = 16'd241;
  localparam logic [15:0] prerender_line  = 16'd261;

  // Active-low sync windows, both ends inclusive
  localparam logic [15:0] hsync_start     = 16'd275;
  localparam logic [15:0] hsync_end       = 16'd300;
  localparam logic [15:0] vsync_start     = 16'd242;
  localparam logic [15:0] vsync_end       = 16'd244;

  typedef logic [15:0] dot_count_t;

  // Loopy layout of the VRAM cursor
  typedef struct packed
  {
    logic [2:0] fine_y;
    logic       nametable_y;
    logic       nametable_x;
    logic [4:0] coarse_y;
    logic [4:0] coarse_x;
  } vram_addr_t;

  // Two dots per fetch, four fetches per tile
  typedef enum logic [1:0] {nametable, attribute, pattern_lo, pattern_hi} fetch_phase_e;

  typedef struct packed
  {
    logic       tick;
    dot_count_t x;
    dot_count_t y;
  } dot_pos_t;

  typedef struct packed
  {
    logic [1:0] attr;
    logic [1:0] value;
  } pixel_t;

  typedef struct packed
  {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

endpackage

// File: list.f
hdl/video_pkg.sv
hdl/host_pkg.sv
hdl/dot_timer.sv
hdl/host_regs.sv
hdl/bg_fetch.sv
hdl/pixel_out.sv
hdl/ppu_top.sv
verification/ppu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PPU background testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module ppu_tb -f list.f -o ppu_sim

./obj_dir/ppu_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: verification/ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb;
  import video_pkg::*;
  import host_pkg::*;

  localparam int frame_clocks   = int'(dots_per_line) * int'(lines_per_frame) * 4;
  // About three frames
  localparam int timeout_cycles = 1_070_000;

  logic        I_clock;
  logic        I_reset;
  host_reg_e   host_addr;
  logic [7:0]  host_data;
  logic        host_wren;
  logic        host_rden;
  logic [7:0]  host_rdata;
  logic        nmi;
  logic [13:0] vid_addr;
  logic [7:0]  vid_wdata;
  logic [7:0]  vid_rdata;
  logic        vid_wren;
  logic        vid_rise;
  logic        blank;
  logic        hsync;
  logic        vsync;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;

  logic [7:0]  vram [0:16383];
  logic [23:0] color_ref [0:63];
  int          error_count = 0;
  int          test_count = 0;
  int          failed_tests = 0;
  int          test_start_errors = 0;
  int          cycle_count = 0;
  int          wren_pulses = 0;
  logic        seen_wren;
  logic [13:0] seen_addr;

  ppu_top DUT
  (
    .I_clock    (I_clock),
    .I_reset    (I_reset),
    .host_addr  (host_addr),
    .host_data  (host_data),
    .host_wren  (host_wren),
    .host_rden  (host_rden),
    .host_rdata (host_rdata),
    .nmi        (nmi),
    .vid_addr   (vid_addr),
    .vid_wdata  (vid_wdata),
    .vid_rdata  (vid_rdata),
    .vid_wren   (vid_wren),
    .vid_rise   (vid_rise),
    .blank      (blank),
    .hsync      (hsync),
    .vsync      (vsync),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

  initial
  begin
    I_clock = 1'b0;
    forever #10 I_clock = ~I_clock;
  end

  //////////////////////////////////////////////////
  // VRAM model with asynchronous read

  assign vid_rdata = vram[vid_addr];

  always @(posedge I_clock)
  begin
    if (vid_wren)
    begin
      vram[vid_addr] <= vid_wdata;
      wren_pulses    <= wren_pulses + 1;
    end
  end

  // Every address bit shows up in the byte
  function automatic logic [7:0] fill_byte(input logic [13:0] a);
    return a[7:0] ^ {a[13:8], a[13:12]};
  endfunction

  //////////////////////////////////////////////////
  // Host bus accesses of one clock strobe each

  task automatic write_reg(input host_reg_e a, input logic [7:0] d);
    @(posedge I_clock);
    host_addr <= a;
    host_data <= d;
    host_wren <= 1'b1;
    @(negedge I_clock);
    seen_wren = vid_wren;
    seen_addr = vid_addr;
    @(posedge I_clock);
    host_wren <= 1'b0;
  endtask

  task automatic read_reg(input host_reg_e a, output logic [7:0] d);
    @(posedge I_clock);
    host_addr <= a;
    host_rden <= 1'b1;
    @(negedge I_clock);
    d = host_rdata;
    @(posedge I_clock);
    host_rden <= 1'b0;
  endtask

  task automatic set_vram_addr(input logic [13:0] a);
    write_reg(reg_vram_addr, {2'b00, a[13:8]});
    write_reg(reg_vram_addr, a[7:0]);
  endtask

  //////////////////////////////////////////////////
  // Compare tasks

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("ERROR at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_addr(input string what, input logic [13:0] got, input logic [13:0] exp);
    if (got !== exp)
    begin
      $display("ERROR at %0d ns: %s is %04h, expected %04h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_rgb(input string what, input rgb_t got, input rgb_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0d ns: %s is %06h, expected %06h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_count - test_start_errors;
    test_count++;
    if (errs != 0)
      failed_tests++;
    $display("%s: %s, %0d errors", name, (errs == 0) ? "passed" : "did not pass", errs);
    test_start_errors = error_count;
  endtask

  //////////////////////////////////////////////////
  // Directed tests

  task automatic reset_state();
    logic [7:0] rd;
    @(negedge I_clock);
    check_flag("nmi after reset", nmi, 1'b1);
    check_flag("hsync after reset", hsync, 1'b1);
    check_flag("vsync after reset", vsync, 1'b1);
    check_flag("vid_wren after reset", vid_wren, 1'b0);
    read_reg(reg_status, rd);
    check_flag("status bit 7 after reset", rd[7], 1'b0);
    finish_test("reset_state");
  endtask

  task automatic write_run(input logic [13:0] base, input logic [13:0] stride);
    logic [7:0]  data [0:2];
    logic [13:0] a;
    set_vram_addr(base);
    for (int i = 0; i < 3; i++)
    begin
      data[i] = 8'($urandom);
      a = 14'(base + 14'(i) * stride);
      write_reg(reg_vram_data, data[i]);
      check_flag("vid_wren on data write", seen_wren, 1'b1);
      check_addr("vid_addr on data write", seen_addr, a);
    end
    // Last model write lands on the closing edge
    @(negedge I_clock);
    for (int i = 0; i < 3; i++)
    begin
      a = 14'(base + 14'(i) * stride);
      check_byte("VRAM model byte", vram[a], data[i]);
    end
  endtask

  task automatic vram_write();
    write_run(14'h2000, 14'd1);
    write_reg(reg_control, 8'h04);
    write_run(14'h2040, 14'd32);
    write_reg(reg_control, 8'h00);
    finish_test("vram_write");
  endtask

  task automatic buffered_read();
    logic [7:0] rd;
    // Buffer still holds its reset value before any data-port read
    set_vram_addr(14'h2001);
    read_reg(reg_vram_data, rd);
    check_byte("first read at 2001", rd, 8'h00);
    read_reg(reg_vram_data, rd);
    check_byte("second read at 2001", rd, vram[14'h2001]);
    // Stale byte comes from 2002 where the cursor had moved
    set_vram_addr(14'h0123);
    read_reg(reg_vram_data, rd);
    check_byte("first read at 0123", rd, vram[14'h2002]);
    read_reg(reg_vram_data, rd);
    check_byte("second read at 0123", rd, vram[14'h0123]);
    finish_test("buffered_read");
  endtask

  task automatic palette_access();
    logic [5:0] color_a;
    logic [5:0] color_b;
    logic [7:0] rd;
    int         pulses_before;
    color_a = 6'($urandom);
    color_b = 6'($urandom);
    pulses_before = wren_pulses;
    set_vram_addr(14'h3F01);
    write_reg(reg_vram_data, {2'b00, color_a});
    check_flag("vid_wren on palette write", seen_wren, 1'b0);
    set_vram_addr(14'h3F10);
    write_reg(reg_vram_data, {2'b00, color_b});
    check_flag("vid_wren on palette write", seen_wren, 1'b0);
    set_vram_addr(14'h3F01);
    read_reg(reg_vram_data, rd);
    check_byte("palette 3F01", rd & 8'h3F, {2'b00, color_a});
    set_vram_addr(14'h3F10);
    read_reg(reg_vram_data, rd);
    check_byte("palette 3F10", rd & 8'h3F, {2'b00, color_b});
    // 3F10 mirrors onto the backdrop entry
    set_vram_addr(14'h3F00);
    read_reg(reg_vram_data, rd);
    check_byte("palette 3F00", rd & 8'h3F, {2'b00, color_b});
    if (wren_pulses != pulses_before)
    begin
      $display("ERROR at %0d ns: vid_wren pulsed %0d times during palette access",
               $time, wren_pulses - pulses_before);
      error_count++;
    end
    finish_test("palette_access");
  endtask

  task automatic wait_nmi_low();
    int waited;
    waited = 0;
    while ((nmi !== 1'b0) && (waited < frame_clocks + 100))
    begin
      @(negedge I_clock);
      waited++;
    end
    if (nmi !== 1'b0)
    begin
      $display("nmi never went low within one frame");
      error_count++;
    end
  endtask

  task automatic vblank_nmi();
    logic [7:0] rd;
    write_reg(reg_control, 8'h80);
    wait_nmi_low();
    read_reg(reg_status, rd);
    check_flag("status bit 7 in vblank", rd[7], 1'b1);
    @(negedge I_clock);
    check_flag("nmi after status read", nmi, 1'b1);
    read_reg(reg_status, rd);
    check_flag("status bit 7 after clear", rd[7], 1'b0);
    write_reg(reg_control, 8'h00);
    finish_test("vblank_nmi");
  endtask

  task automatic background_render();
    logic [5:0] color_idx;
    logic [5:0] backdrop_idx;
    rgb_t       expected;
    logic       was_blank;
    int         line;
    int         dot_n;
    int         samples;
    color_idx = 6'($urandom);
    expected  = rgb_t'(color_ref[color_idx]);
    // Backdrop gets a colour unlike the tile colour
    backdrop_idx = (color_ref[color_idx] == color_ref[6'h0F]) ? 6'h30 : 6'h0F;

    // Nametable 0 holds tile 1 with all attributes zero
    set_vram_addr(14'h2000);
    for (int i = 0; i < 960; i++)
      write_reg(reg_vram_data, 8'h01);
    for (int i = 0; i < 64; i++)
      write_reg(reg_vram_data, 8'h00);
    // Tile 1 has its low plane set and its high plane clear
    set_vram_addr(14'h0010);
    for (int i = 0; i < 16; i++)
      write_reg(reg_vram_data, (i < 8) ? 8'hFF : 8'h00);
    set_vram_addr(14'h3F00);
    write_reg(reg_vram_data, {2'b00, backdrop_idx});
    write_reg(reg_vram_data, {2'b00, color_idx});
    // Scroll to the top left of nametable 0
    set_vram_addr(14'h0000);
    write_reg(reg_scroll, 8'h00);
    write_reg(reg_scroll, 8'h00);
    write_reg(reg_mask, 8'h0A);

    while (vsync !== 1'b0)
      @(negedge I_clock);
    while (vsync !== 1'b1)
      @(negedge I_clock);

    // Each rise of blank starts a visible line
    line = -1;
    was_blank = 1'b0;
    while (line < 100)
    begin
      @(negedge I_clock);
      if (blank && !was_blank)
        line++;
      was_blank = blank;
    end

    dot_n = 1;
    samples = 0;
    while (blank)
    begin
      if (vid_rise && (dot_n >= 100) && (dot_n <= 200))
      begin
        check_rgb("rgb on line 100", rgb_t'({red, green, blue}), expected);
        samples++;
      end
      if (vid_rise)
        dot_n++;
      @(negedge I_clock);
    end
    if (samples != 101)
    begin
      $display("Only %0d of 101 pixels on line 100 were sampled", samples);
      error_count++;
    end

    // Hsync low from dot 275 to dot 300
    while (dot_n < 341)
    begin
      if (vid_rise)
      begin
        check_flag("hsync on line 100", hsync, !((dot_n >= 275) && (dot_n <= 300)));
        dot_n++;
      end
      @(negedge I_clock);
    end
    write_reg(reg_mask, 8'h00);
    finish_test("background_render");
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog

  initial
  begin
    void'($urandom(32'h8ba8_8d51));
    I_reset   = 1'b0;
    host_addr = reg_control;
    host_data = 8'h00;
    host_wren = 1'b0;
    host_rden = 1'b0;
    for (int i = 0; i < 16384; i++)
      vram[i] = fill_byte(14'(i));
    $readmemh("hdl/nes_colors.mem", color_ref);

    repeat (8) @(posedge I_clock);
    I_reset <= 1'b1;

    reset_state();
    vram_write();
    buffered_read();
    palette_access();
    vblank_nmi();
    background_render();

    $display("Summary: %0d tests, %0d failed, %0d check errors",
             test_count, failed_tests, error_count);
    if (error_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    while (cycle_count < timeout_cycles)
    begin
      @(posedge I_clock);
      cycle_count++;
    end
    $display("Run timed out after %0d clock cycles", cycle_count);
    $display("Test FAILED");
    $finish;
  end

endmodule
